/* include/svf_macros.svh */
`ifndef SVF_MACROS_SVH
`define SVF_MACROS_SVH

// sample and coefficient words are Q5.16.
`define SVF_SAMPLE_W 21

// full signed product of two words.
`define SVF_PROD_W 42

// product bits kept after a multiply realign the result to Q5.16.
`define SVF_FRAC_LSB 16
`define SVF_FRAC_MSB 36

// mixer clamp limits of -2^20 and 2^20-1.
`define SVF_SAMPLE_MAX 21'sh0FFFFF
`define SVF_SAMPLE_MIN 21'sh100000

`endif

/* design/svf_types_pkg.sv */
`include "svf_macros.svh"

package svf_types_pkg;

    typedef logic signed [`SVF_SAMPLE_W-1:0] sample_t;

    // encoded 0 to 3 in response selector order.
    typedef enum logic [1:0] {
        mode_lowpass,
        mode_bandpass,
        mode_highpass,
        mode_notch
    } filter_mode_e;

    typedef enum logic [1:0] {
        mix_a,
        mix_b,
        mix_sum,
        mix_diff
    } mix_mode_e;

    // signed Q5.16 multiply that keeps bits 36 down to 16 of the full product.
    function automatic sample_t mul_q16(sample_t a, sample_t b);
        logic signed [`SVF_PROD_W-1:0] p;
        p = a * b;
        return p[`SVF_FRAC_MSB:`SVF_FRAC_LSB];
    endfunction

endpackage

/* design/svf_ctrl_pkg.sv */
package svf_ctrl_pkg;

    // configuration write opcodes.
    typedef enum logic [2:0] {
        op_set_f_a,
        op_set_q_a,
        op_set_mode_a,
        op_set_f_b,
        op_set_q_b,
        op_set_mode_b,
        op_set_mix
    } cfg_op_e;

endpackage

/* design/svf_coef_if.sv */
`timescale 1ns/10ps

// coefficient set and response mode of one filter channel.
interface svf_coef_if
    import svf_types_pkg::*;
();

    sample_t      f;
    sample_t      q;
    sample_t      f_q;
    sample_t      f_f_q;
    filter_mode_e mode;

    modport ctrl (
        output f,
        output q,
        output f_q,
        output f_f_q,
        output mode
    );

    modport core (
        input f,
        input q,
        input f_q,
        input f_f_q,
        input mode
    );

endinterface

/* design/svf_coef_ctrl.sv */
`timescale 1ns/10ps

module svf_coef_ctrl
    import svf_types_pkg::*;
    import svf_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cfg_valid,
    input  cfg_op_e   cfg_op,
    input  sample_t   cfg_data,
    output mix_mode_e mix,
    svf_coef_if.ctrl  coef_a,
    svf_coef_if.ctrl  coef_b
);

    filter_mode_e data_mode;
    mix_mode_e    data_mix;

    // mode fields sit in the low bits of the data word.
    assign data_mode = filter_mode_e'(cfg_data[1:0]);
    assign data_mix  = mix_mode_e'(cfg_data[1:0]);

    // primary registers are written straight from the config strobe.
    always_ff @(posedge clk) begin
        if (rst) begin
            coef_a.f    <= '0;
            coef_a.q    <= '0;
            coef_a.mode <= mode_lowpass;
            coef_b.f    <= '0;
            coef_b.q    <= '0;
            coef_b.mode <= mode_lowpass;
            mix         <= mix_a;
        end else if (cfg_valid) begin
            case (cfg_op)
                op_set_f_a: begin
                    coef_a.f <= cfg_data;
                end
                op_set_q_a: begin
                    coef_a.q <= cfg_data;
                end
                op_set_mode_a: begin
                    coef_a.mode <= data_mode;
                end
                op_set_f_b: begin
                    coef_b.f <= cfg_data;
                end
                op_set_q_b: begin
                    coef_b.q <= cfg_data;
                end
                op_set_mode_b: begin
                    coef_b.mode <= data_mode;
                end
                op_set_mix: begin
                    mix <= data_mix;
                end
                default: begin
                end
            endcase
        end
    end

    // f+q settles one cycle after a write.
    always_ff @(posedge clk) begin
        if (rst) begin
            coef_a.f_q <= '0;
            coef_b.f_q <= '0;
        end else begin
            coef_a.f_q <= coef_a.f + coef_a.q;
            coef_b.f_q <= coef_b.f + coef_b.q;
        end
    end

    // f(f+q) uses the registered sum, so it settles one cycle later.
    always_ff @(posedge clk) begin
        if (rst) begin
            coef_a.f_f_q <= '0;
            coef_b.f_f_q <= '0;
        end else begin
            coef_a.f_f_q <= mul_q16(coef_a.f, coef_a.f_q);
            coef_b.f_f_q <= mul_q16(coef_b.f, coef_b.f_q);
        end
    end

endmodule

/* design/svf_core.sv */
`timescale 1ns/10ps

module svf_core
    import svf_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  sample_t  x,
    svf_coef_if.core coef,
    output sample_t  y,
    output logic     out_valid
);

    // integrator states; highpass and notch are rebuilt from these each sample.
    sample_t bp;
    sample_t lp;

    sample_t f_bp;
    sample_t fq_bp;
    sample_t ffq_bp;
    sample_t f_x;
    sample_t f_lp;

    sample_t hp_n;
    sample_t bp_n;
    sample_t lp_n;
    sample_t notch_n;

    // all products are taken from the old state.
    assign f_bp   = mul_q16(coef.f, bp);
    assign fq_bp  = mul_q16(coef.f_q, bp);
    assign ffq_bp = mul_q16(coef.f_f_q, bp);
    assign f_x    = mul_q16(coef.f, x);
    assign f_lp   = mul_q16(coef.f, lp);

    assign hp_n    = x - fq_bp - lp;
    assign bp_n    = f_x - ffq_bp - f_lp;
    assign lp_n    = f_bp + lp;
    assign notch_n = x - fq_bp + f_bp;

    always_ff @(posedge clk) begin
        if (rst) begin
            bp <= '0;
            lp <= '0;
        end else if (in_valid) begin
            bp <= bp_n;
            lp <= lp_n;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            y <= '0;
        end else if (in_valid) begin
            case (coef.mode)
                mode_lowpass:  y <= lp_n;
                mode_bandpass: y <= bp_n;
                mode_highpass: y <= hp_n;
                mode_notch:    y <= notch_n;
                default:       y <= lp_n;
            endcase
        end
    end

    // one cycle of latency.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

/* design/svf_mixer.sv */
`timescale 1ns/10ps

`include "svf_macros.svh"

module svf_mixer
    import svf_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  sample_t   y_a,
    input  sample_t   y_b,
    input  mix_mode_e mix,
    output sample_t   sample_out,
    output logic      out_valid
);

    // one guard bit so the sum or difference cannot wrap.
    logic signed [`SVF_SAMPLE_W:0] wide;
    sample_t                       clamped;
    sample_t                       mixed;

    assign wide = (mix == mix_diff) ? y_a - y_b : y_a + y_b;

    // top two bits differ only when the result is out of range.
    assign clamped = (wide[`SVF_SAMPLE_W] == wide[`SVF_SAMPLE_W-1]) ?
                     sample_t'(wide[`SVF_SAMPLE_W-1:0]) :
                     (wide[`SVF_SAMPLE_W] ? `SVF_SAMPLE_MIN : `SVF_SAMPLE_MAX);

    always_comb begin
        case (mix)
            mix_a:   mixed = y_a;
            mix_b:   mixed = y_b;
            default: mixed = clamped;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_out <= '0;
        end else if (in_valid) begin
            sample_out <= mixed;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

/* design/dual_svf.sv */
`timescale 1ns/10ps

`include "svf_macros.svh"

module dual_svf
    import svf_types_pkg::*;
    import svf_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cfg_valid,
    input  logic [2:0]               cfg_op,
    input  logic [`SVF_SAMPLE_W-1:0] cfg_data,
    input  logic                     in_valid,
    input  logic [`SVF_SAMPLE_W-1:0] sample_in,
    output logic [`SVF_SAMPLE_W-1:0] sample_out,
    output logic                     out_valid
);

    svf_coef_if coef_a ();
    svf_coef_if coef_b ();

    mix_mode_e mix;
    sample_t   y_a;
    sample_t   y_b;
    logic      core_valid;

    svf_coef_ctrl svf_coef_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .cfg_valid (cfg_valid),
        .cfg_op    (cfg_op_e'(cfg_op)),
        .cfg_data  (cfg_data),
        .mix       (mix),
        .coef_a    (coef_a.ctrl),
        .coef_b    (coef_b.ctrl)
    );

    svf_core core_a (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .x         (sample_in),
        .coef      (coef_a.core),
        .y         (y_a),
        .out_valid (core_valid)
    );

    // same timing as core_a, so its valid is not needed.
    svf_core core_b (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .x         (sample_in),
        .coef      (coef_b.core),
        .y         (y_b),
        .out_valid ()
    );

    svf_mixer svf_mixer_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (core_valid),
        .y_a        (y_a),
        .y_b        (y_b),
        .mix        (mix),
        .sample_out (sample_out),
        .out_valid  (out_valid)
    );

endmodule

/* bench/dual_svf_sva.sv */
`timescale 1ns/10ps

`include "svf_macros.svh"

module dual_svf_sva (
    input logic                     clk,
    input logic                     rst,
    input logic                     in_valid,
    input logic                     out_valid,
    input logic [`SVF_SAMPLE_W-1:0] sample_out
);

    // nothing comes out in the cycle after a reset edge.
    reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // core stage plus mixer stage.
    two_cycle_latency: assert property (
        @(posedge clk) disable iff (rst) out_valid == $past(in_valid, 2)
    ) else $error("out_valid does not follow in_valid by two cycles");

    output_hold: assert property (
        @(posedge clk) disable iff (rst) !out_valid |-> $stable(sample_out)
    ) else $error("sample_out changed without out_valid");

endmodule

bind dual_svf dual_svf_sva dual_svf_sva_inst (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .sample_out (sample_out)
);

/* bench/dual_svf_tb.sv */
`timescale 1ns/10ps

`include "svf_macros.svh"

module dual_svf_tb
    import svf_types_pkg::*;
    import svf_ctrl_pkg::*;
();

    localparam int max_level = (1 << 20) - 1;
    localparam int min_level = -(1 << 20);

    logic                     clk;
    logic                     rst;
    logic                     cfg_valid;
    logic [2:0]               cfg_op;
    logic [`SVF_SAMPLE_W-1:0] cfg_data;
    logic                     in_valid;
    logic [`SVF_SAMPLE_W-1:0] sample_in;
    logic [`SVF_SAMPLE_W-1:0] sample_out;
    logic                     out_valid;

    // reference state with channel a at index 0.
    sample_t      m_f [2];
    sample_t      m_q [2];
    sample_t      m_bp [2];
    sample_t      m_lp [2];
    filter_mode_e m_mode [2];
    mix_mode_e    m_mix;

    sample_t     exp_q [$];
    int          exp_cycle [$];
    int          cycle = 0;
    int          errors;
    logic [31:0] lcg_state;

    dual_svf dual_svf_inst (
        .clk        (clk),
        .rst        (rst),
        .cfg_valid  (cfg_valid),
        .cfg_op     (cfg_op),
        .cfg_data   (cfg_data),
        .in_valid   (in_valid),
        .sample_in  (sample_in),
        .sample_out (sample_out),
        .out_valid  (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_range(int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:8]) % n;
    endfunction

    function automatic sample_t rand_sample(int span);
        return sample_t'(rand_range(2 * span + 1) - span);
    endfunction

    // q5.16 product keeping bits 36 down to 16 of the full result.
    function automatic sample_t fixed_mul(sample_t a, sample_t b);
        longint prod;
        prod = longint'(a) * longint'(b);
        return prod[`SVF_FRAC_MSB:`SVF_FRAC_LSB];
    endfunction

    function automatic sample_t clamp_mix(sample_t a, sample_t b, bit subtract);
        int total;
        total = subtract ? int'(a) - int'(b) : int'(a) + int'(b);
        if (total > max_level) begin
            total = max_level;
        end else if (total < min_level) begin
            total = min_level;
        end
        return sample_t'(total);
    endfunction

    function automatic void reset_model();
        for (int ch = 0; ch < 2; ch++) begin
            m_f[ch] = '0;
            m_q[ch] = '0;
            m_bp[ch] = '0;
            m_lp[ch] = '0;
            m_mode[ch] = mode_lowpass;
        end
        m_mix = mix_a;
        exp_q.delete();
        exp_cycle.delete();
    endfunction

    task automatic model_step(input sample_t x, output sample_t y);
        sample_t y_ch [2];
        sample_t fq;
        sample_t ffq;
        sample_t hp;
        sample_t bp;
        sample_t lp;
        sample_t nt;
        for (int ch = 0; ch < 2; ch++) begin
            fq = m_f[ch] + m_q[ch];
            ffq = fixed_mul(m_f[ch], fq);
            hp = x - fixed_mul(fq, m_bp[ch]) - m_lp[ch];
            bp = fixed_mul(m_f[ch], x) - fixed_mul(ffq, m_bp[ch]) - fixed_mul(m_f[ch], m_lp[ch]);
            lp = fixed_mul(m_f[ch], m_bp[ch]) + m_lp[ch];
            nt = x - fixed_mul(fq, m_bp[ch]) + fixed_mul(m_f[ch], m_bp[ch]);
            case (m_mode[ch])
                mode_lowpass:  y_ch[ch] = lp;
                mode_bandpass: y_ch[ch] = bp;
                mode_highpass: y_ch[ch] = hp;
                default:       y_ch[ch] = nt;
            endcase
            m_bp[ch] = bp;
            m_lp[ch] = lp;
        end
        case (m_mix)
            mix_a:   y = y_ch[0];
            mix_b:   y = y_ch[1];
            mix_sum: y = clamp_mix(y_ch[0], y_ch[1], 1'b0);
            default: y = clamp_mix(y_ch[0], y_ch[1], 1'b1);
        endcase
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic write_cfg(input cfg_op_e op, input sample_t data);
        @(negedge clk);
        in_valid = 1'b0;
        cfg_valid = 1'b1;
        cfg_op = op;
        cfg_data = data;
        @(negedge clk);
        cfg_valid = 1'b0;
        case (op)
            op_set_f_a:    m_f[0] = data;
            op_set_q_a:    m_q[0] = data;
            op_set_mode_a: m_mode[0] = filter_mode_e'(data[1:0]);
            op_set_f_b:    m_f[1] = data;
            op_set_q_b:    m_q[1] = data;
            op_set_mode_b: m_mode[1] = filter_mode_e'(data[1:0]);
            default:       m_mix = mix_mode_e'(data[1:0]);
        endcase
    endtask

    task automatic send_sample(input sample_t x);
        sample_t y;
        @(negedge clk);
        in_valid = 1'b1;
        sample_in = x;
        model_step(x, y);
        exp_q.push_back(y);
        exp_cycle.push_back(cycle + 2);
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected outputs never arrived", exp_q.size());
            $display("SOME TESTS FAILED");
            $finish;
        end
    endtask

    // every valid output must match the oldest pending sample.
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("%0t: output appeared with no sample pending", $time);
            end else begin
                if (exp_cycle[0] != cycle) begin
                    errors++;
                    $display("%0t: output came at cycle %0d, expected at cycle %0d",
                             $time, cycle, exp_cycle[0]);
                end
                if (sample_out !== exp_q[0]) begin
                    errors++;
                    $display("MISMATCH at %0t: sample_out got %0d expected %0d",
                             $time, $signed(sample_out), exp_q[0]);
                end
                void'(exp_q.pop_front());
                void'(exp_cycle.pop_front());
            end
        end
    end

    task automatic check_reset_state();
        repeat (4) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                errors++;
                $display("MISMATCH at %0t: out_valid got %b expected 0", $time, out_valid);
            end
            if (sample_out !== '0) begin
                errors++;
                $display("MISMATCH at %0t: sample_out got %0d expected 0",
                         $time, $signed(sample_out));
            end
        end
    endtask

    task automatic lowpass_step_response();
        write_cfg(op_set_f_a, sample_t'(8192));
        write_cfg(op_set_q_a, sample_t'(16384));
        write_cfg(op_set_mode_a, sample_t'(mode_lowpass));
        write_cfg(op_set_mix, sample_t'(mix_a));
        idle(3);
        send_sample(sample_t'(65536));
        repeat (7) send_sample('0);
        repeat (12) send_sample(sample_t'(32768));
        drain_outputs();
    endtask

    task automatic channel_b_modes();
        write_cfg(op_set_mix, sample_t'(mix_b));
        for (int i = 0; i < 4; i++) begin
            write_cfg(op_set_f_b, sample_t'(2000 + rand_range(18000)));
            write_cfg(op_set_q_b, sample_t'(2000 + rand_range(30000)));
            write_cfg(op_set_mode_b, sample_t'(filter_mode_e'(i[1:0])));
            idle(3);
            repeat (16) send_sample(rand_sample(100000));
            drain_outputs();
        end
    endtask

    task automatic valid_gap_timing();
        repeat (10) send_sample(rand_sample(200000));
        for (int i = 0; i < 20; i++) begin
            idle(rand_range(4));
            send_sample(rand_sample(200000));
        end
        drain_outputs();
    endtask

    // state carries over the rewrite.
    task automatic coef_rewrite_midstream();
        write_cfg(op_set_mix, sample_t'(mix_a));
        write_cfg(op_set_mode_a, sample_t'(mode_bandpass));
        write_cfg(op_set_f_a, sample_t'(6000));
        write_cfg(op_set_q_a, sample_t'(12000));
        idle(3);
        repeat (10) send_sample(rand_sample(150000));
        write_cfg(op_set_f_a, sample_t'(14000));
        write_cfg(op_set_q_a, sample_t'(4000));
        idle(3);
        repeat (10) send_sample(rand_sample(150000));
        drain_outputs();
    endtask

    // f=1 and q=-1 move the input into the lowpass state, and f=0 then holds it.
    task automatic load_lowpass_b(input sample_t level);
        write_cfg(op_set_f_b, sample_t'(65536));
        write_cfg(op_set_q_b, sample_t'(-65536));
        write_cfg(op_set_mode_b, sample_t'(mode_lowpass));
        idle(3);
        send_sample(level);
        send_sample('0);
        write_cfg(op_set_f_b, '0);
        write_cfg(op_set_q_b, '0);
        idle(3);
    endtask

    task automatic sum_diff_clamping();
        @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        reset_model();
        // f=0 highpass passes the input, so the sum is twice the input.
        write_cfg(op_set_mode_a, sample_t'(mode_highpass));
        write_cfg(op_set_mode_b, sample_t'(mode_highpass));
        write_cfg(op_set_mix, sample_t'(mix_sum));
        idle(3);
        send_sample(sample_t'(900000));
        send_sample(sample_t'(-900000));
        repeat (12) send_sample(rand_sample(1000000));
        drain_outputs();
        load_lowpass_b(sample_t'(600000));
        write_cfg(op_set_mode_a, sample_t'(mode_notch));
        write_cfg(op_set_mix, sample_t'(mix_diff));
        idle(3);
        send_sample(sample_t'(-900000));
        repeat (12) send_sample(rand_sample(1000000));
        drain_outputs();
        load_lowpass_b(sample_t'(-600000));
        send_sample(sample_t'(900000));
        repeat (12) send_sample(rand_sample(1000000));
        drain_outputs();
        // channels now differ, so the sum sees both inputs.
        write_cfg(op_set_mix, sample_t'(mix_sum));
        repeat (12) send_sample(rand_sample(1000000));
        drain_outputs();
    endtask

    initial begin
        rst = 1'b1;
        cfg_valid = 1'b0;
        cfg_op = '0;
        cfg_data = '0;
        in_valid = 1'b0;
        sample_in = '0;
        errors = 0;
        lcg_state = 32'd62600;
        reset_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        lowpass_step_response();
        channel_b_modes();
        valid_gap_timing();
        coef_rewrite_midstream();
        sum_diff_clamping();
        idle(2);
        $display("tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* dual_svf.f */
+incdir+include
design/svf_types_pkg.sv
design/svf_ctrl_pkg.sv
design/svf_coef_if.sv
design/svf_coef_ctrl.sv
design/svf_core.sv
design/svf_mixer.sv
design/dual_svf.sv
bench/dual_svf_sva.sv
bench/dual_svf_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the dual_svf testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --top-module dual_svf_tb \
    --Mdir "$build_dir" \
    -o dual_svf_sim \
    -f dual_svf.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/dual_svf_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$log_file"; then
    echo "result: fail"
    exit 1
fi

echo "result: pass"
exit 0
